// ==== src/readout_cfg.svh ====
// build-time sizes; RO_N_CHANNELS must fit in RO_BUS_DATA_W bits and stay below 2**RO_ID_W
`ifndef READOUT_CFG_SVH
`define READOUT_CFG_SVH

// number of front-end receive channels
`define RO_N_CHANNELS 4

// decoded word width as delivered by a channel
`define RO_PAYLOAD_W 24
// identifier sits in the top bits of each output word
`define RO_ID_W 8
// must equal RO_ID_W + RO_PAYLOAD_W
`define RO_WORD_W 32

// per-channel FIFO depth is 2**RO_FIFO_AW
`define RO_FIFO_AW 3

// register bus
`define RO_BUS_ADDR_W 16
`define RO_BUS_DATA_W 8
`define RO_REG_ENABLE 16'h8800
`define RO_REG_OVERFLOW 16'h8801
`define RO_REG_FLUSH 16'h8802

`endif

// ==== src/readout_pkg.sv ====
// shared readout types; widths follow readout_cfg.svh, which must be on the include path
`include "readout_cfg.svh"

package readout_pkg;

    // one decoded word from a front-end channel
    typedef logic [`RO_PAYLOAD_W-1:0] payload_t;
    // identifier in the upper bits, payload below
    typedef logic [`RO_WORD_W-1:0] rx_word_t;
    // one bit per channel
    typedef logic [`RO_N_CHANNELS-1:0] chan_mask_t;

    typedef logic [`RO_BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`RO_BUS_DATA_W-1:0] bus_data_t;

    // strobes decoded once per cycle
    typedef enum logic [1:0] {BUS_IDLE, BUS_READ, BUS_WRITE} bus_op_e;
    // arbiter output register occupancy
    typedef enum logic {OUT_EMPTY, OUT_FULL} out_state_e;

endpackage

// ==== src/rx_ctrl_regs.sv ====
// read and write strobes must be single-cycle and never both high; read data lags one cycle
`timescale 1ns/100ps
`include "readout_cfg.svh"

module rx_ctrl_regs
(
    input  logic                    CLK_40,
    input  logic                    i_rst,
    input  readout_pkg::bus_addr_t  i_bus_add,
    input  readout_pkg::bus_data_t  i_bus_wdata,
    input  logic                    i_bus_wr,
    input  logic                    i_bus_rd,
    input  readout_pkg::chan_mask_t i_overflow,
    output readout_pkg::bus_data_t  o_bus_rdata,
    output readout_pkg::chan_mask_t o_enable,
    output readout_pkg::chan_mask_t o_flush
);

    localparam int N = `RO_N_CHANNELS;

    readout_pkg::bus_op_e    bus_op;
    readout_pkg::chan_mask_t wr_mask;
    readout_pkg::chan_mask_t enable_q;
    readout_pkg::chan_mask_t overflow_q;
    readout_pkg::bus_data_t  rd_value;

    // write wins if both strobes ever show up
    always_comb
    begin
        if (i_bus_wr)
            bus_op = readout_pkg::BUS_WRITE;
        else if (i_bus_rd)
            bus_op = readout_pkg::BUS_READ;
        else
            bus_op = readout_pkg::BUS_IDLE;
    end

    // only the low channel bits carry meaning
    assign wr_mask = i_bus_wdata[N-1:0];

    // read mux, flush reg and unmapped space give zero
    always_comb
    begin
        rd_value = '0;
        if (i_bus_add == `RO_REG_ENABLE)
            rd_value[N-1:0] = enable_q;
        else if (i_bus_add == `RO_REG_OVERFLOW)
            rd_value[N-1:0] = overflow_q;
    end

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            enable_q    <= '0;
            overflow_q  <= '0;
            o_flush     <= '0;
            o_bus_rdata <= '0;
        end
        else
        begin
            // flush is a one-cycle pulse
            o_flush    <= '0;
            // new overflow pulses always land, even against a clear
            overflow_q <= overflow_q | i_overflow;
            case (bus_op)
                readout_pkg::BUS_WRITE:
                begin
                    if (i_bus_add == `RO_REG_ENABLE)
                        enable_q <= wr_mask;
                    else if (i_bus_add == `RO_REG_OVERFLOW)
                        overflow_q <= (overflow_q & ~wr_mask) | i_overflow;
                    else if (i_bus_add == `RO_REG_FLUSH)
                        o_flush <= wr_mask;
                end
                readout_pkg::BUS_READ:
                    o_bus_rdata <= rd_value;
                default:
                    o_bus_rdata <= o_bus_rdata;
            endcase
        end
    end

    // gates arbiter requests
    assign o_enable = enable_q;

endmodule

// ==== src/rx_channel.sv ====
// i_valid has no back-pressure and words offered while full are lost; i_pop only when non-empty
`timescale 1ns/100ps
`include "readout_cfg.svh"

module rx_channel
#(
    parameter int CHAN_INDEX = 0
)
(
    input  logic                  CLK_40,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  readout_pkg::payload_t i_data,
    input  logic                  i_flush,
    input  logic                  i_pop,
    output logic                  o_empty,
    output readout_pkg::rx_word_t o_word,
    output logic                  o_overflow
);

    localparam int AW    = `RO_FIFO_AW;
    localparam int DEPTH = 1 << AW;
    // data identifier is channel index plus one
    localparam logic [`RO_ID_W-1:0] DATA_ID = `RO_ID_W'(CHAN_INDEX + 1);

    readout_pkg::payload_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign full    = (count == (AW+1)'(DEPTH));
    assign o_empty = (count == '0);

    // a write alongside a flush is dropped
    assign wr_en = i_valid && !full && !i_flush;
    // flush overrides a pop
    assign rd_en = i_pop && !o_empty && !i_flush;

    // storage
    always_ff @(posedge CLK_40)
    begin
        if (wr_en)
            mem[wr_ptr] <= i_data;
    end

    // pointers and count
    always_ff @(posedge CLK_40)
    begin
        if (i_rst || i_flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:
                    count <= count + 1'b1;
                2'b01:
                    count <= count - 1'b1;
                default:
                    count <= count;
            endcase
        end
    end

    // one-cycle pulse per lost word
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
            o_overflow <= 1'b0;
        else
            o_overflow <= i_valid && full;
    end

    // head falls through, tagged
    assign o_word = {DATA_ID, mem[rd_ptr]};

endmodule

// ==== src/rr_arbiter.sv ====
// grants at most one non-empty enabled channel per cycle; o_out_data holds while valid and not ready
`timescale 1ns/100ps
`include "readout_cfg.svh"

module rr_arbiter
(
    input  logic                                      CLK_40,
    input  logic                                      i_rst,
    input  readout_pkg::chan_mask_t                   i_empty,
    input  readout_pkg::chan_mask_t                   i_enable,
    input  readout_pkg::rx_word_t [`RO_N_CHANNELS-1:0] i_words,
    input  logic                                      i_out_ready,
    output readout_pkg::chan_mask_t                   o_pop,
    output logic                                      o_out_valid,
    output readout_pkg::rx_word_t                     o_out_data
);

    localparam int N     = `RO_N_CHANNELS;
    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    readout_pkg::out_state_e out_state;
    readout_pkg::chan_mask_t req;

    logic [PTR_W-1:0] rr_ptr;
    logic [PTR_W-1:0] grant_idx;
    logic [PTR_W-1:0] next_ptr;
    logic             grant_any;
    logic             load;

    // only channels with data and enabled
    assign req = ~i_empty & i_enable;

    // rotating priority, search starts at rr_ptr and wraps
    always_comb
    begin
        int idx;
        grant_idx = rr_ptr;
        grant_any = 1'b0;
        for (int i = 0; i < N; i++)
        begin
            idx = (int'(rr_ptr) + i) % N;
            if (!grant_any && req[idx])
            begin
                grant_idx = PTR_W'(idx);
                grant_any = 1'b1;
            end
        end
    end

    // load when the output slot is free or draining this cycle
    assign load = grant_any && ((out_state == readout_pkg::OUT_EMPTY) || i_out_ready);

    // one-hot pop, nothing under back-pressure
    assign o_pop = load ? (readout_pkg::chan_mask_t'(1) << grant_idx) : '0;

    // next search starts just past the winner
    assign next_ptr = (grant_idx == PTR_W'(N - 1)) ? '0 : grant_idx + 1'b1;

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            out_state <= readout_pkg::OUT_EMPTY;
            rr_ptr    <= '0;
        end
        else if (load)
        begin
            out_state <= readout_pkg::OUT_FULL;
            rr_ptr    <= next_ptr;
        end
        else if (i_out_ready)
        begin
            // drained with nothing behind it
            out_state <= readout_pkg::OUT_EMPTY;
        end
    end

    // payload register
    always_ff @(posedge CLK_40)
    begin
        if (load)
            o_out_data <= i_words[grant_idx];
    end

    assign o_out_valid = (out_state == readout_pkg::OUT_FULL);

endmodule

// ==== src/readout_top.sv ====
// single clock domain CLK_40; receive inputs have no back-pressure, words beyond FIFO depth are lost
`timescale 1ns/100ps
`include "readout_cfg.svh"

module readout_top
(
    input  logic                                       CLK_40,
    input  logic                                       i_rst,
    input  readout_pkg::bus_addr_t                     i_bus_add,
    input  readout_pkg::bus_data_t                     i_bus_wdata,
    input  logic                                       i_bus_wr,
    input  logic                                       i_bus_rd,
    output readout_pkg::bus_data_t                     o_bus_rdata,
    input  readout_pkg::chan_mask_t                    i_rx_valid,
    input  readout_pkg::payload_t [`RO_N_CHANNELS-1:0] i_rx_data,
    output logic                                       o_out_valid,
    output readout_pkg::rx_word_t                      o_out_data,
    input  logic                                       i_out_ready
);

    localparam int N = `RO_N_CHANNELS;

    readout_pkg::chan_mask_t       enable;
    readout_pkg::chan_mask_t       flush;
    readout_pkg::chan_mask_t       overflow;
    readout_pkg::chan_mask_t       empty;
    readout_pkg::chan_mask_t       pop;
    readout_pkg::rx_word_t [N-1:0] words;

    // configuration and monitoring
    rx_ctrl_regs u_regs
    (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_bus_add   (i_bus_add),
        .i_bus_wdata (i_bus_wdata),
        .i_bus_wr    (i_bus_wr),
        .i_bus_rd    (i_bus_rd),
        .i_overflow  (overflow),
        .o_bus_rdata (o_bus_rdata),
        .o_enable    (enable),
        .o_flush     (flush)
    );

    // one buffer per front-end, identifier k+1
    generate
        for (genvar k = 0; k < N; k++)
        begin : g_chan
            rx_channel #(.CHAN_INDEX(k)) u_chan
            (
                .CLK_40     (CLK_40),
                .i_rst      (i_rst),
                .i_valid    (i_rx_valid[k]),
                .i_data     (i_rx_data[k]),
                .i_flush    (flush[k]),
                .i_pop      (pop[k]),
                .o_empty    (empty[k]),
                .o_word     (words[k]),
                .o_overflow (overflow[k])
            );
        end
    endgenerate

    // merge into the output stream
    rr_arbiter u_arb
    (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_empty     (empty),
        .i_enable    (enable),
        .i_words     (words),
        .i_out_ready (i_out_ready),
        .o_pop       (pop),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
// free-running clock from time zero; reset is released on a falling edge after RST_CYCLES edges
`timescale 1ns/100ps

module tb_clock_gen
#(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 8
)
(
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // release away from the rising edge
    initial
    begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// ==== tests/readout_properties.sv ====
// bound into every rr_arbiter instance; sampled on CLK_40, handshake checks idle while i_rst is high
`timescale 1ns/100ps

module readout_properties
(
    input logic                    CLK_40,
    input logic                    i_rst,
    input readout_pkg::chan_mask_t i_empty,
    input readout_pkg::chan_mask_t i_pop,
    input logic                    i_out_valid,
    input logic                    i_out_ready,
    input readout_pkg::rx_word_t   i_out_data
);

    // stalled word stays put and stays valid
    a_hold_stable: assert property (@(posedge CLK_40) disable iff (i_rst)
        i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_data))
        else $error("output word changed or dropped while stalled");

    // at most one grant per cycle
    a_pop_onehot: assert property (@(posedge CLK_40) disable iff (i_rst)
        $onehot0(i_pop))
        else $error("more than one channel popped in one cycle");

    // grants only go to channels holding data
    a_pop_not_empty: assert property (@(posedge CLK_40) disable iff (i_rst)
        (i_pop & i_empty) == '0)
        else $error("pop issued to an empty channel");

    // output register cleared by reset
    a_reset_idle: assert property (@(posedge CLK_40)
        i_rst |=> !i_out_valid)
        else $error("output valid seen during reset");

endmodule

bind rr_arbiter readout_properties u_props
(
    .CLK_40      (CLK_40),
    .i_rst       (i_rst),
    .i_empty     (i_empty),
    .i_pop       (o_pop),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_out_data  (o_out_data)
);

// ==== tests/readout_tb.sv ====
// order and overflow cases assume 4 channels and FIFO depth 8; stops at the first error
`timescale 1ns/100ps
`include "readout_cfg.svh"

module readout_tb;

    localparam int N       = `RO_N_CHANNELS;
    localparam int CW      = $clog2(N);
    localparam int TBL_LEN = 16;

    typedef struct packed {
        logic [CW-1:0]         chan;
        readout_pkg::payload_t payload;
        logic [7:0]            ready_pct;
    } stim_t;

    // channel, payload, chance of ready in percent
    localparam stim_t STIM [TBL_LEN] = '{
        '{2'd0, 24'h0a0001, 8'd100},
        '{2'd1, 24'h1b0002, 8'd100},
        '{2'd2, 24'h2c0003, 8'd80},
        '{2'd3, 24'h3d0004, 8'd80},
        '{2'd0, 24'h0a0005, 8'd50},
        '{2'd0, 24'h0a0006, 8'd50},
        '{2'd2, 24'h2c0007, 8'd30},
        '{2'd1, 24'h1b0008, 8'd30},
        '{2'd3, 24'h3d0009, 8'd60},
        '{2'd3, 24'h3d000a, 8'd60},
        '{2'd1, 24'h1b000b, 8'd40},
        '{2'd2, 24'h2c000c, 8'd40},
        '{2'd0, 24'hffffff, 8'd90},
        '{2'd1, 24'h000000, 8'd90},
        '{2'd2, 24'h5a5a5a, 8'd70},
        '{2'd3, 24'ha5a5a5, 8'd70}
    };

    logic                          clk;
    logic                          rst;
    readout_pkg::bus_addr_t        bus_add;
    readout_pkg::bus_data_t        bus_wdata;
    logic                          bus_wr;
    logic                          bus_rd;
    readout_pkg::bus_data_t        bus_rdata;
    readout_pkg::chan_mask_t       rx_valid;
    readout_pkg::payload_t [N-1:0] rx_data;
    logic                          out_valid;
    readout_pkg::rx_word_t         out_data;
    logic                          out_ready;

    integer seed = 32'hcaea0d55;
    int     ready_pct = 100;
    // per-channel expectations, plus a strict order queue for the round-robin case
    readout_pkg::rx_word_t exp_q [N][$];
    readout_pkg::rx_word_t order_q [$];

    tb_clock_gen #(.PERIOD_NS(20), .RST_CYCLES(8)) u_clk
    (
        .o_clk (clk),
        .o_rst (rst)
    );

    readout_top dut0
    (
        .CLK_40      (clk),
        .i_rst       (rst),
        .i_bus_add   (bus_add),
        .i_bus_wdata (bus_wdata),
        .i_bus_wr    (bus_wr),
        .i_bus_rd    (bus_rd),
        .o_bus_rdata (bus_rdata),
        .i_rx_valid  (rx_valid),
        .i_rx_data   (rx_data),
        .o_out_valid (out_valid),
        .o_out_data  (out_data),
        .i_out_ready (out_ready)
    );

    task automatic fail_now();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input readout_pkg::rx_word_t exp, input readout_pkg::rx_word_t act,
                              input string name);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_reg(input readout_pkg::bus_data_t exp, input readout_pkg::bus_data_t act,
                             input string name);
        if (act !== exp)
        begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_now();
        end
    endtask

    // identifier is channel plus one, payload below it
    function automatic readout_pkg::rx_word_t make_word(input int ch,
                                                        input readout_pkg::payload_t p);
        return {`RO_ID_W'(ch + 1), p};
    endfunction

    function automatic int pending_words();
        int total;
        total = order_q.size();
        for (int k = 0; k < N; k++)
            total += exp_q[k].size();
        return total;
    endfunction

    task automatic bus_write(input readout_pkg::bus_addr_t addr,
                             input readout_pkg::bus_data_t data);
        @(negedge clk);
        bus_add   = addr;
        bus_wdata = data;
        bus_wr    = 1'b1;
        @(negedge clk);
        bus_wr    = 1'b0;
    endtask

    // read data is registered on the strobe edge, stable by the next falling edge
    task automatic bus_read(input readout_pkg::bus_addr_t addr,
                            output readout_pkg::bus_data_t data);
        @(negedge clk);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge clk);
        bus_rd  = 1'b0;
        data    = bus_rdata;
    endtask

    // ordered queue first, else the queue picked by the identifier
    task automatic score_word(input readout_pkg::rx_word_t w);
        int id;
        id = int'(w[`RO_WORD_W-1 -: `RO_ID_W]);
        if (order_q.size() > 0)
            check_word(order_q.pop_front(), w, "o_out_data");
        else if (id >= 1 && id <= N && exp_q[id-1].size() > 0)
            check_word(exp_q[id-1].pop_front(), w, "o_out_data");
        else
        begin
            $display("an output word %h appeared that no channel was sent", w);
            fail_now();
        end
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (pending_words() != 0 || out_valid)
        begin
            @(negedge clk);
            n++;
            if (n > max_cycles)
            begin
                $display("the output stream stalled with words still outstanding");
                fail_now();
            end
        end
    endtask

    // transfers seen at the rising edge
    always @(posedge clk)
    begin
        if (!rst && out_valid && out_ready)
            score_word(out_data);
    end

    // ready toggles with the current entry's probability
    initial
    begin
        out_ready = 1'b0;
        forever
        begin
            @(negedge clk);
            out_ready = ((($random(seed) & 32'h7fffffff) % 100) < ready_pct);
        end
    end

    initial
    begin
        repeat (TBL_LEN * 40 + 2000) @(posedge clk);
        $display("the run timed out before all tests finished");
        fail_now();
    end

    initial
    begin
        readout_pkg::bus_data_t rd;
        int gap;
        int ch;
        bus_add   = '0;
        bus_wdata = '0;
        bus_wr    = 1'b0;
        bus_rd    = 1'b0;
        rx_valid  = '0;
        rx_data   = '0;
        @(negedge clk);
        while (rst)
            @(negedge clk);

        // idle after reset
        if (out_valid !== 1'b0)
        begin
            $display("Fail at %0t: o_out_valid expected 0, got %b", $time, out_valid);
            fail_now();
        end
        bus_read(`RO_REG_ENABLE, rd);
        check_reg(8'h00, rd, "enable register");
        bus_read(`RO_REG_OVERFLOW, rd);
        check_reg(8'h00, rd, "overflow register");

        // upper bits are not stored
        bus_write(`RO_REG_ENABLE, 8'hf5);
        bus_read(`RO_REG_ENABLE, rd);
        check_reg(8'h05, rd, "enable register");

        // pointer still at channel 0, so a full load drains 0,1,2,3,0,1,2,3
        bus_write(`RO_REG_ENABLE, 8'h00);
        for (int r = 0; r < 2; r++)
        begin
            @(negedge clk);
            rx_valid = '1;
            for (int k = 0; k < N; k++)
            begin
                rx_data[k] = readout_pkg::payload_t'(24'h400000 + r * 16 + k);
                order_q.push_back(make_word(k, rx_data[k]));
            end
        end
        @(negedge clk);
        rx_valid = '0;
        bus_write(`RO_REG_ENABLE, 8'h0f);
        wait_drained(100);

        // table under random ready and random input gaps
        for (int i = 0; i < TBL_LEN; i++)
        begin
            @(posedge clk);
            gap = ($random(seed) & 32'h7fffffff) % 3;
            @(negedge clk);
            ch           = int'(STIM[i].chan);
            ready_pct    = int'(STIM[i].ready_pct);
            rx_valid     = '0;
            rx_valid[ch] = 1'b1;
            rx_data[ch]  = STIM[i].payload;
            exp_q[ch].push_back(make_word(ch, STIM[i].payload));
            @(negedge clk);
            rx_valid = '0;
            repeat (gap) @(negedge clk);
        end
        ready_pct = 100;
        wait_drained(TBL_LEN * 20);

        // overfill disabled channel 2, ten words into eight slots
        bus_write(`RO_REG_ENABLE, 8'h0b);
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            rx_valid   = 4'b0100;
            rx_data[2] = readout_pkg::payload_t'(24'h600000 + i);
        end
        @(negedge clk);
        rx_valid = '0;
        repeat (2) @(negedge clk);
        bus_read(`RO_REG_OVERFLOW, rd);
        check_reg(8'h04, rd, "overflow register");
        bus_write(`RO_REG_OVERFLOW, 8'h04);
        bus_read(`RO_REG_OVERFLOW, rd);
        check_reg(8'h00, rd, "overflow register");
        // flushed words must never reach the output
        bus_write(`RO_REG_FLUSH, 8'h04);
        bus_write(`RO_REG_ENABLE, 8'h0f);
        repeat (50) @(negedge clk);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+src
src/readout_pkg.sv
src/rx_ctrl_regs.sv
src/rx_channel.sv
src/rr_arbiter.sv
src/readout_top.sv
tests/tb_clock_gen.sv
tests/readout_properties.sv
tests/readout_tb.sv

// ==== Makefile ====
# Verilator build and run of the readout testbench

VERILATOR ?= verilator
TOP       ?= readout_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

# the run's exit status is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
